/* src/hmr_tmr_pkg.sv */
//////////////////////////////////////////////////
// Shared definitions of the TMR control unit
//   mode encoding, register request, per-group
//   configuration, core status and control outputs,
//   counter width and configuration bit positions
//////////////////////////////////////////////////

package hmr_tmr_pkg;

  // Lockstep modes of one core group
  typedef enum logic [1:0] {
    NON_TMR,
    TMR_RUN,
    TMR_UNLOAD,
    TMR_RELOAD
  } tmr_mode_e;

  typedef struct packed {
    logic tmr_enable;
    logic delay_resynch;
    logic setback;
    logic reload_setback;
    logic rapid_recovery;
    logic force_resynch;
  } tmr_cfg_t;

  // Single-cycle strobe port, read data is combinational
  typedef struct packed {
    logic       valid;
    logic       write;
    logic [3:0] addr;
    logic [7:0] wdata;
  } tmr_reg_req_t;

  typedef struct packed {
    logic       single_mismatch;
    logic [2:0] error;
    logic       failure;
    logic       sp_store_is_zero;
    logic       sp_store_will_be_zero;
    logic       fetch_en;
    logic       cores_synch;
  } tmr_core_status_t;

  typedef struct packed {
    logic [2:0] setback;
    logic       sw_resynch_req;
    logic       sw_synch_req;
    logic       grp_in_independent;
    logic       rapid_recovery_en;
  } tmr_ctrl_out_t;

  localparam int unsigned CntWidth = 8;

  // Group g sits at address GrpCfgBase + g
  localparam logic [3:0] GrpCfgBase = 4'h0;

  // Configuration field positions in wdata and rdata
  localparam int unsigned CfgTmrEnableBit     = 0;
  localparam int unsigned CfgDelayResynchBit  = 1;
  localparam int unsigned CfgSetbackBit       = 2;
  localparam int unsigned CfgReloadSetbackBit = 3;
  localparam int unsigned CfgRapidRecoveryBit = 4;
  localparam int unsigned CfgForceResynchBit  = 5;

endpackage

/* src/hmr_tmr_cfg_regs.sv */
//////////////////////////////////////////////////
// Per-group TMR configuration registers
//   write strobe decode, combinational readback,
//   force_resynch cleared by the controller ack
//////////////////////////////////////////////////

`timescale 1ns/1ps

module hmr_tmr_cfg_regs #(
  parameter int unsigned NumGroups = 2,
  parameter bit          TMRFixed  = 1'b0
) (
  input  logic                                   clk_i,
  input  logic                                   rst_ni,
  input  hmr_tmr_pkg::tmr_reg_req_t              req_i,
  output logic [7:0]                             rdata_o,
  input  logic [NumGroups-1:0]                   force_ack_i,
  output hmr_tmr_pkg::tmr_cfg_t [NumGroups-1:0]  cfg_o
);

  import hmr_tmr_pkg::*;

  tmr_cfg_t [NumGroups-1:0] cfg_q;
  logic     [NumGroups-1:0] grp_sel;
  tmr_cfg_t                 wr_cfg;

  function automatic tmr_cfg_t unpack_cfg(logic [7:0] data);
    tmr_cfg_t cfg;
    cfg.tmr_enable     = data[CfgTmrEnableBit];
    cfg.delay_resynch  = data[CfgDelayResynchBit];
    cfg.setback        = data[CfgSetbackBit];
    cfg.reload_setback = data[CfgReloadSetbackBit];
    cfg.rapid_recovery = data[CfgRapidRecoveryBit];
    cfg.force_resynch  = data[CfgForceResynchBit];
    return cfg;
  endfunction

  function automatic logic [7:0] pack_cfg(tmr_cfg_t cfg);
    logic [7:0] data;
    data                      = '0;
    data[CfgTmrEnableBit]     = cfg.tmr_enable;
    data[CfgDelayResynchBit]  = cfg.delay_resynch;
    data[CfgSetbackBit]       = cfg.setback;
    data[CfgReloadSetbackBit] = cfg.reload_setback;
    data[CfgRapidRecoveryBit] = cfg.rapid_recovery;
    data[CfgForceResynchBit]  = cfg.force_resynch;
    return data;
  endfunction

  assign wr_cfg = unpack_cfg(req_i.wdata);

  // Address decode, addresses past the last group select nothing
  always_comb begin
    for (int unsigned g = 0; g < NumGroups; g++) begin
      grp_sel[g] = req_i.valid && (req_i.addr == 4'(GrpCfgBase + g));
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q <= '0;
    end else begin
      for (int unsigned g = 0; g < NumGroups; g++) begin
        // A write in the same cycle wins over the ack
        if (grp_sel[g] && req_i.write) begin
          cfg_q[g] <= wr_cfg;
        end else if (force_ack_i[g]) begin
          cfg_q[g].force_resynch <= 1'b0;
        end
      end
    end
  end

  // Fixed TMR keeps every group enabled
  always_comb begin
    cfg_o = cfg_q;
    if (TMRFixed) begin
      for (int unsigned g = 0; g < NumGroups; g++) begin
        cfg_o[g].tmr_enable = 1'b1;
      end
    end
  end

  always_comb begin
    rdata_o = '0;
    for (int unsigned g = 0; g < NumGroups; g++) begin
      if (grp_sel[g] && !req_i.write) begin
        rdata_o = pack_cfg(cfg_o[g]);
      end
    end
  end

endmodule

/* src/hmr_tmr_ctrl.sv */
//////////////////////////////////////////////////
// Lockstep mode FSM for one TMR core group
//   setback, resynch and synch requests,
//   per-core mismatch increments, force ack
//////////////////////////////////////////////////

`timescale 1ns/1ps

module hmr_tmr_ctrl #(
  parameter bit TMRFixed      = 1'b0,
  parameter bit DefaultInTMR  = TMRFixed,
  parameter bit RapidRecovery = 1'b0
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  hmr_tmr_pkg::tmr_cfg_t         cfg_i,
  input  hmr_tmr_pkg::tmr_core_status_t status_i,
  output hmr_tmr_pkg::tmr_ctrl_out_t    ctrl_o,
  output logic                          force_ack_o,
  output logic [2:0]                    incr_o
);

  import hmr_tmr_pkg::*;

  localparam tmr_mode_e DefaultMode = (TMRFixed || DefaultInTMR) ? TMR_RUN : NON_TMR;

  tmr_mode_e mode_d, mode_q;

  assign ctrl_o.grp_in_independent = (mode_q == NON_TMR);
  assign ctrl_o.rapid_recovery_en  = cfg_i.rapid_recovery & RapidRecovery;

  always_comb begin
    mode_d                = mode_q;
    ctrl_o.setback        = 3'b000;
    ctrl_o.sw_resynch_req = 1'b0;
    ctrl_o.sw_synch_req   = 1'b0;
    force_ack_o           = 1'b0;
    incr_o                = 3'b000;

    case (mode_q)
      TMR_RUN: begin
        // Forced resynch is acked even while it is delayed
        if (cfg_i.force_resynch) begin
          force_ack_o = 1'b1;
          if (!cfg_i.delay_resynch) begin
            mode_d = TMR_UNLOAD;
          end
        end
        if (status_i.single_mismatch) begin
          incr_o = status_i.error;
          if (!cfg_i.delay_resynch) begin
            mode_d = TMR_UNLOAD;
          end
        end
      end

      TMR_UNLOAD: begin
        ctrl_o.sw_resynch_req = 1'b1;
        // State saved, reset the cores and reload
        if (!status_i.sp_store_is_zero) begin
          mode_d = TMR_RELOAD;
          if (cfg_i.setback) begin
            ctrl_o.setback = 3'b111;
          end
        end
      end

      TMR_RELOAD: begin
        if (status_i.sp_store_is_zero) begin
          mode_d = TMR_RUN;
        end else if ((status_i.single_mismatch || status_i.failure) &&
                     cfg_i.setback && cfg_i.reload_setback &&
                     !status_i.sp_store_will_be_zero) begin
          // Error during reload, start over
          ctrl_o.setback = 3'b111;
        end
      end

      default: ;
    endcase

    // Switching in and out of TMR
    if (!TMRFixed) begin
      // Before the cores fetch, the mode just follows the enable bit
      if (!status_i.fetch_en) begin
        mode_d = cfg_i.tmr_enable ? TMR_RUN : NON_TMR;
      end
      if (mode_q == TMR_RUN && !cfg_i.tmr_enable) begin
        mode_d = NON_TMR;
        if (cfg_i.setback) begin
          ctrl_o.setback = 3'b110;
        end
      end
      // Wait for software to bring the cores to a common point
      if (mode_q == NON_TMR && cfg_i.tmr_enable) begin
        ctrl_o.sw_synch_req = 1'b1;
        if (status_i.cores_synch) begin
          mode_d = TMR_RELOAD;
          if (cfg_i.setback) begin
            ctrl_o.setback = 3'b111;
          end
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q <= DefaultMode;
    end else begin
      mode_q <= mode_d;
    end
  end

endmodule

/* src/hmr_tmr_mismatch_cnt.sv */
//////////////////////////////////////////////////
// Saturating mismatch counters
//   three per group, one per core
//////////////////////////////////////////////////

`timescale 1ns/1ps

module hmr_tmr_mismatch_cnt #(
  parameter int unsigned NumGroups = 2
) (
  input  logic                                               clk_i,
  input  logic                                               rst_ni,
  input  logic [NumGroups-1:0][2:0]                          incr_i,
  output logic [NumGroups-1:0][2:0][hmr_tmr_pkg::CntWidth-1:0] cnt_o
);

  import hmr_tmr_pkg::*;

  localparam logic [CntWidth-1:0] CntMax = '1;

  logic [NumGroups-1:0][2:0][CntWidth-1:0] cnt_q;
  logic [NumGroups-1:0][2:0][CntWidth-1:0] cnt_d;

  // Stop at the top value instead of wrapping
  always_comb begin
    cnt_d = cnt_q;
    for (int unsigned g = 0; g < NumGroups; g++) begin
      for (int unsigned c = 0; c < 3; c++) begin
        if (incr_i[g][c] && (cnt_q[g][c] != CntMax)) begin
          cnt_d[g][c] = cnt_q[g][c] + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  assign cnt_o = cnt_q;

endmodule

/* src/hmr_tmr_unit.sv */
//////////////////////////////////////////////////
// TMR control unit top level
//   configuration registers, one lockstep
//   controller per group, mismatch counters
//////////////////////////////////////////////////

`timescale 1ns/1ps

module hmr_tmr_unit #(
  parameter int unsigned NumGroups     = 2,
  parameter bit          TMRFixed      = 1'b0,
  parameter bit          DefaultInTMR  = TMRFixed,
  parameter bit          RapidRecovery = 1'b0
) (
  input  logic                                                 clk_i,
  input  logic                                                 rst_ni,
  input  hmr_tmr_pkg::tmr_reg_req_t                            reg_req_i,
  output logic [7:0]                                           reg_rdata_o,
  input  hmr_tmr_pkg::tmr_core_status_t [NumGroups-1:0]        status_i,
  output hmr_tmr_pkg::tmr_ctrl_out_t [NumGroups-1:0]           ctrl_o,
  output logic [NumGroups-1:0][2:0][hmr_tmr_pkg::CntWidth-1:0] cnt_o
);

  import hmr_tmr_pkg::*;

  tmr_cfg_t [NumGroups-1:0]       grp_cfg;
  logic     [NumGroups-1:0]       force_ack;
  logic     [NumGroups-1:0][2:0]  incr;

  hmr_tmr_cfg_regs #(
    .NumGroups(NumGroups),
    .TMRFixed (TMRFixed)
  ) i_cfg_regs (
    .clk_i,
    .rst_ni,
    .req_i      (reg_req_i),
    .rdata_o    (reg_rdata_o),
    .force_ack_i(force_ack),
    .cfg_o      (grp_cfg)
  );

  for (genvar g = 0; g < NumGroups; g++) begin : gen_grp_ctrl
    hmr_tmr_ctrl #(
      .TMRFixed     (TMRFixed),
      .DefaultInTMR (DefaultInTMR),
      .RapidRecovery(RapidRecovery)
    ) i_ctrl (
      .clk_i,
      .rst_ni,
      .cfg_i      (grp_cfg[g]),
      .status_i   (status_i[g]),
      .ctrl_o     (ctrl_o[g]),
      .force_ack_o(force_ack[g]),
      .incr_o     (incr[g])
    );
  end

  hmr_tmr_mismatch_cnt #(
    .NumGroups(NumGroups)
  ) i_mismatch_cnt (
    .clk_i,
    .rst_ni,
    .incr_i(incr),
    .cnt_o (cnt_o)
  );

endmodule

/* tests/tb_clk_gen.sv */
//////////////////////////////////////////////////
// Testbench clock and reset source
//   free-running clock, active-low reset
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned PeriodNs    = 20,
  parameter int unsigned ResetCycles = 8
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // Release just after an edge, away from the sampling points
  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #2;
    rst_no = 1'b1;
  end

endmodule

/* tests/tb_hmr_tmr_checker.sv */
//////////////////////////////////////////////////
// Testbench checker for the TMR control unit
//   reference model of modes, configuration
//   and counters, per-cycle output comparison
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_hmr_tmr_checker #(
  parameter int unsigned NumGroups     = 2,
  parameter bit          RapidRecovery = 1'b0
) (
  input  logic                                                 clk_i,
  input  logic                                                 rst_ni,
  input  hmr_tmr_pkg::tmr_reg_req_t                            reg_req_i,
  input  logic [7:0]                                           reg_rdata_i,
  input  hmr_tmr_pkg::tmr_core_status_t [NumGroups-1:0]        status_i,
  input  hmr_tmr_pkg::tmr_ctrl_out_t [NumGroups-1:0]           ctrl_i,
  input  logic [NumGroups-1:0][2:0][hmr_tmr_pkg::CntWidth-1:0] cnt_i,
  output int unsigned                                          errors_o
);

  import hmr_tmr_pkg::*;

  typedef struct packed {
    tmr_ctrl_out_t ctrl;
    logic [2:0]    incr;
    logic          force_ack;
    tmr_mode_e     mode_next;
  } ref_t;

  tmr_mode_e           mode_m [NumGroups];
  tmr_cfg_t            cfg_m  [NumGroups];
  logic [CntWidth-1:0] cnt_m  [NumGroups][3];
  ref_t                exp_r  [NumGroups];
  int unsigned         err_count = 0;

  assign errors_o = err_count;

  function automatic logic [7:0] cfg_to_byte(tmr_cfg_t c);
    logic [7:0] b;
    b                      = '0;
    b[CfgTmrEnableBit]     = c.tmr_enable;
    b[CfgDelayResynchBit]  = c.delay_resynch;
    b[CfgSetbackBit]       = c.setback;
    b[CfgReloadSetbackBit] = c.reload_setback;
    b[CfgRapidRecoveryBit] = c.rapid_recovery;
    b[CfgForceResynchBit]  = c.force_resynch;
    return b;
  endfunction

  function automatic tmr_cfg_t byte_to_cfg(logic [7:0] b);
    tmr_cfg_t c;
    c.tmr_enable     = b[CfgTmrEnableBit];
    c.delay_resynch  = b[CfgDelayResynchBit];
    c.setback        = b[CfgSetbackBit];
    c.reload_setback = b[CfgReloadSetbackBit];
    c.rapid_recovery = b[CfgRapidRecoveryBit];
    c.force_resynch  = b[CfgForceResynchBit];
    return c;
  endfunction

  // Expected outputs and next mode of one group, TMR is optional here
  function automatic ref_t expected_step(tmr_mode_e mode, tmr_cfg_t cfg,
                                         tmr_core_status_t st);
    ref_t r;
    r                         = '0;
    r.mode_next               = mode;
    r.ctrl.grp_in_independent = (mode == NON_TMR);
    r.ctrl.rapid_recovery_en  = cfg.rapid_recovery && RapidRecovery;
    if (mode == TMR_RUN) begin
      r.force_ack = cfg.force_resynch;
      if (st.single_mismatch) begin
        r.incr = st.error;
      end
      if ((cfg.force_resynch || st.single_mismatch) && !cfg.delay_resynch) begin
        r.mode_next = TMR_UNLOAD;
      end
    end else if (mode == TMR_UNLOAD) begin
      r.ctrl.sw_resynch_req = 1'b1;
      if (!st.sp_store_is_zero) begin
        r.mode_next    = TMR_RELOAD;
        r.ctrl.setback = cfg.setback ? 3'b111 : 3'b000;
      end
    end else if (mode == TMR_RELOAD) begin
      if (st.sp_store_is_zero) begin
        r.mode_next = TMR_RUN;
      end else if ((st.single_mismatch || st.failure) && cfg.setback &&
                   cfg.reload_setback && !st.sp_store_will_be_zero) begin
        r.ctrl.setback = 3'b111;
      end
    end
    // Switching rules, applied after the mode rules
    if (!st.fetch_en) begin
      r.mode_next = cfg.tmr_enable ? TMR_RUN : NON_TMR;
    end
    if (mode == TMR_RUN && !cfg.tmr_enable) begin
      r.mode_next    = NON_TMR;
      r.ctrl.setback = cfg.setback ? 3'b110 : 3'b000;
    end
    if (mode == NON_TMR && cfg.tmr_enable) begin
      r.ctrl.sw_synch_req = 1'b1;
      if (st.cores_synch) begin
        r.mode_next    = TMR_RELOAD;
        r.ctrl.setback = cfg.setback ? 3'b111 : 3'b000;
      end
    end
    return r;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
    $display("Mismatch at %0t: %s expected %0h got %0h", $time, name, exp_v, act_v);
    err_count++;
  endtask

  // Outputs are settled mid-cycle, inputs are held until after the next edge
  always @(negedge clk_i) begin
    logic [7:0] exp_rdata;
    if (rst_ni) begin
      exp_rdata = '0;
      for (int unsigned g = 0; g < NumGroups; g++) begin
        exp_r[g] = expected_step(mode_m[g], cfg_m[g], status_i[g]);
        if (ctrl_i[g] !== exp_r[g].ctrl) begin
          report_mismatch($sformatf("ctrl_o[%0d]", g), 32'(exp_r[g].ctrl), 32'(ctrl_i[g]));
        end
        for (int unsigned c = 0; c < 3; c++) begin
          if (cnt_i[g][c] !== cnt_m[g][c]) begin
            report_mismatch($sformatf("cnt_o[%0d][%0d]", g, c), 32'(cnt_m[g][c]),
                            32'(cnt_i[g][c]));
          end
        end
        if (32'(reg_req_i.addr) == g) begin
          exp_rdata = cfg_to_byte(cfg_m[g]);
        end
      end
      if (reg_req_i.valid && !reg_req_i.write) begin
        if (reg_rdata_i !== exp_rdata) begin
          report_mismatch("reg_rdata_o", 32'(exp_rdata), 32'(reg_rdata_i));
        end
      end
    end
  end

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned g = 0; g < NumGroups; g++) begin
        mode_m[g] = NON_TMR;
        cfg_m[g]  = '0;
        for (int unsigned c = 0; c < 3; c++) begin
          cnt_m[g][c] = '0;
        end
      end
    end else begin
      for (int unsigned g = 0; g < NumGroups; g++) begin
        if (reg_req_i.valid && reg_req_i.write && 32'(reg_req_i.addr) == g) begin
          cfg_m[g] = byte_to_cfg(reg_req_i.wdata);
        end else if (exp_r[g].force_ack) begin
          cfg_m[g].force_resynch = 1'b0;
        end
        mode_m[g] = exp_r[g].mode_next;
        for (int unsigned c = 0; c < 3; c++) begin
          if (exp_r[g].incr[c] && cnt_m[g][c] != '1) begin
            cnt_m[g][c] = cnt_m[g][c] + 1'b1;
          end
        end
      end
    end
  end

endmodule

/* tests/tb_hmr_tmr_unit.sv */
//////////////////////////////////////////////////
// Testbench top for the TMR control unit
//   DUT, clock source and checker instances,
//   directed and seeded tests, watchdog, summary
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_hmr_tmr_unit;

  import hmr_tmr_pkg::*;

  localparam int unsigned NumGroups     = 2;
  localparam int unsigned NumTests      = 6;
  localparam int unsigned PeriodNs      = 20;
  localparam int unsigned ResetCycles   = 8;
  localparam int unsigned TimeoutCycles = NumTests * 200 + ResetCycles;
  localparam int unsigned WaitLimit     = 50;

  // Control output selectors for the wait task
  localparam int unsigned SelResynch = 0;
  localparam int unsigned SelSynch   = 1;
  localparam int unsigned SelIndep   = 2;

  logic                                    clk;
  logic                                    rst_n;
  tmr_reg_req_t                            reg_req;
  logic [7:0]                              reg_rdata;
  tmr_core_status_t [NumGroups-1:0]        status;
  tmr_ctrl_out_t [NumGroups-1:0]           ctrl;
  logic [NumGroups-1:0][2:0][CntWidth-1:0] cnt;
  int unsigned                             chk_errors;
  int unsigned                             tb_errors    = 0;
  int unsigned                             failed_tests = 0;
  int unsigned                             err_mark     = 0;
  int                                      seed         = 67;

  // Mismatches driven per core while the group is in TMR_RUN
  int unsigned                             mismatch_hits [NumGroups][3];

  tb_clk_gen #(
    .PeriodNs   (PeriodNs),
    .ResetCycles(ResetCycles)
  ) i_clk_gen (
    .clk_o (clk),
    .rst_no(rst_n)
  );

  hmr_tmr_unit #(
    .NumGroups    (NumGroups),
    .RapidRecovery(1'b1)
  ) i_dut (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .reg_req_i  (reg_req),
    .reg_rdata_o(reg_rdata),
    .status_i   (status),
    .ctrl_o     (ctrl),
    .cnt_o      (cnt)
  );

  tb_hmr_tmr_checker #(
    .NumGroups    (NumGroups),
    .RapidRecovery(1'b1)
  ) i_checker (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .reg_req_i  (reg_req),
    .reg_rdata_i(reg_rdata),
    .status_i   (status),
    .ctrl_i     (ctrl),
    .cnt_i      (cnt),
    .errors_o   (chk_errors)
  );

  // Inputs change 2 ns after the rising edge
  task automatic step();
    @(posedge clk);
    #2;
  endtask

  task automatic check_value(input string what, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    if (exp_v !== act_v) begin
      $display("Mismatch at %0t: %s expected %0h got %0h", $time, what, exp_v, act_v);
      tb_errors++;
    end
  endtask

  task automatic check_ctrl(input int unsigned g, input logic [6:0] exp_v, input string what);
    @(negedge clk);
    check_value(what, 32'(exp_v), 32'(ctrl[g]));
    step();
  endtask

  task automatic reg_write(input int unsigned addr, input logic [7:0] data);
    reg_req = '{valid: 1'b1, write: 1'b1, addr: 4'(addr), wdata: data};
    step();
    reg_req = '0;
  endtask

  task automatic reg_read(input int unsigned addr, output logic [7:0] data);
    reg_req = '{valid: 1'b1, write: 1'b0, addr: 4'(addr), wdata: 8'h00};
    @(negedge clk);
    data = reg_rdata;
    step();
    reg_req = '0;
  endtask

  task automatic wait_ctrl(input int unsigned g, input int unsigned sel, input logic val,
                           input string what);
    int unsigned n;
    logic        cur;
    n = 0;
    do begin
      @(negedge clk);
      case (sel)
        SelResynch: cur = ctrl[g].sw_resynch_req;
        SelSynch:   cur = ctrl[g].sw_synch_req;
        default:    cur = ctrl[g].grp_in_independent;
      endcase
      n++;
    end while (cur !== val && n < WaitLimit);
    if (cur !== val) begin
      $display("Group %0d did not reach %s within %0d cycles", g, what, WaitLimit);
      tb_errors++;
    end
    step();
  endtask

  function automatic logic [2:0] rand_error();
    logic [2:0] e;
    e = 3'($random(seed));
    if (e == 3'b000) begin
      e = 3'b001;
    end
    return e;
  endfunction

  task automatic note_mismatch(input int unsigned g, input logic [2:0] e);
    for (int unsigned c = 0; c < 3; c++) begin
      if (e[c]) begin
        mismatch_hits[g][c]++;
      end
    end
  endtask

  task automatic idle_status();
    for (int unsigned g = 0; g < NumGroups; g++) begin
      status[g]                  = '0;
      status[g].sp_store_is_zero = 1'b1;
    end
  endtask

  task automatic finish_test(input int unsigned num, input string name);
    int unsigned errs;
    string       verdict;
    errs    = tb_errors + chk_errors - err_mark;
    verdict = "ok";
    if (errs != 0) begin
      failed_tests++;
      verdict = "failed";
    end
    $display("Test %0d %s: %s, %0d errors", num, name, verdict, errs);
    err_mark = tb_errors + chk_errors;
  endtask

  task automatic test_reset_readback();
    logic [7:0] data;
    logic [7:0] rd;
    for (int unsigned g = 0; g < NumGroups; g++) begin
      check_value($sformatf("ctrl_o[%0d] after reset", g), 32'h02, 32'(ctrl[g]));
    end
    for (int unsigned g = 0; g < NumGroups; g++) begin
      // Random fields with rapid recovery always on
      data = (8'($random(seed)) & 8'h1e) | 8'h10;
      reg_write(g, data);
      reg_read(g, rd);
      check_value($sformatf("reg_rdata_o group %0d", g), 32'(data), 32'(rd));
    end
    // Out-of-range group and the top address
    reg_write(NumGroups, 8'h3f);
    reg_read(NumGroups, rd);
    check_value("reg_rdata_o invalid address", 32'h0, 32'(rd));
    reg_read(15, rd);
    check_value("reg_rdata_o address 15", 32'h0, 32'(rd));
    for (int unsigned g = 0; g < NumGroups; g++) begin
      reg_write(g, 8'h00);
    end
  endtask

  task automatic test_startup();
    for (int unsigned g = 0; g < NumGroups; g++) begin
      reg_write(g, 8'h01);
      wait_ctrl(g, SelIndep, 1'b0, "TMR_RUN");
      reg_write(g, 8'h00);
      wait_ctrl(g, SelIndep, 1'b1, "NON_TMR");
    end
  endtask

  task automatic test_mismatch_recovery();
    // Enable, setback and reload setback
    reg_write(0, 8'h0d);
    wait_ctrl(0, SelIndep, 1'b0, "TMR_RUN");
    status[0].fetch_en        = 1'b1;
    step();
    status[0].single_mismatch = 1'b1;
    status[0].error           = rand_error();
    note_mismatch(0, status[0].error);
    step();
    status[0].single_mismatch = 1'b0;
    status[0].error           = 3'b000;
    wait_ctrl(0, SelResynch, 1'b1, "TMR_UNLOAD");
    status[0].sp_store_is_zero = 1'b0;
    repeat (3) step();
    status[0].failure = 1'b1;
    step();
    status[0].failure          = 1'b0;
    status[0].sp_store_is_zero = 1'b1;
    step();
    check_ctrl(0, 7'h00, "ctrl_o[0] back in TMR_RUN");
    // Delayed resynch keeps counting without leaving TMR_RUN
    reg_write(0, 8'h0f);
    repeat (4) begin
      status[0].single_mismatch = 1'b1;
      status[0].error           = rand_error();
      note_mismatch(0, status[0].error);
      step();
    end
    status[0].single_mismatch = 1'b0;
    status[0].error           = 3'b000;
    step();
    check_ctrl(0, 7'h00, "ctrl_o[0] after delayed mismatches");
  endtask

  task automatic test_force_resynch();
    logic [7:0] rd;
    reg_write(1, 8'h05);
    wait_ctrl(1, SelIndep, 1'b0, "TMR_RUN");
    status[1].fetch_en = 1'b1;
    step();
    reg_write(1, 8'h25);
    wait_ctrl(1, SelResynch, 1'b1, "TMR_UNLOAD after force");
    reg_read(1, rd);
    check_value("reg_rdata_o force_resynch cleared", 32'h05, 32'(rd));
    status[1].sp_store_is_zero = 1'b0;
    repeat (2) step();
    status[1].sp_store_is_zero = 1'b1;
    step();
    check_ctrl(1, 7'h00, "ctrl_o[1] back in TMR_RUN");
  endtask

  task automatic test_mode_switch();
    // Leaving TMR with setback enabled
    reg_write(0, 8'h04);
    wait_ctrl(0, SelIndep, 1'b1, "NON_TMR");
    reg_write(0, 8'h05);
    wait_ctrl(0, SelSynch, 1'b1, "sw_synch_req");
    repeat (3) step();
    check_ctrl(0, 7'h06, "ctrl_o[0] waiting for cores_synch");
    status[0].cores_synch = 1'b1;
    step();
    status[0].cores_synch = 1'b0;
    step();
    check_ctrl(0, 7'h00, "ctrl_o[0] after reload");
  endtask

  task automatic test_groups_saturation();
    reg_write(1, 8'h07);
    status[1].single_mismatch = 1'b1;
    status[1].error           = 3'b111;
    repeat (260) step();
    status[1].single_mismatch = 1'b0;
    status[1].error           = 3'b000;
    step();
    @(negedge clk);
    for (int unsigned c = 0; c < 3; c++) begin
      check_value($sformatf("cnt_o[1][%0d] saturated", c), 32'hff, 32'(cnt[1][c]));
      check_value($sformatf("cnt_o[0][%0d] untouched", c), 32'(mismatch_hits[0][c]),
                  32'(cnt[0][c]));
    end
    step();
    check_ctrl(0, 7'h00, "ctrl_o[0] untouched");
  endtask

  initial begin
    reg_req = '0;
    idle_status();
    @(posedge rst_n);
    step();
    test_reset_readback();
    finish_test(1, "reset and readback");
    test_startup();
    finish_test(2, "startup");
    test_mismatch_recovery();
    finish_test(3, "mismatch recovery");
    test_force_resynch();
    finish_test(4, "forced resynch");
    test_mode_switch();
    finish_test(5, "mode switching");
    test_groups_saturation();
    finish_test(6, "groups and saturation");
    $display("Summary: %0d tests, %0d failed, %0d errors", NumTests, failed_tests,
             tb_errors + chk_errors);
    if (failed_tests == 0 && tb_errors + chk_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Watchdog sized from the test budget
  initial begin
    #(TimeoutCycles * PeriodNs);
    $display("Timeout: the tests did not finish within %0d cycles", TimeoutCycles);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

/* src.f */
src/hmr_tmr_pkg.sv
src/hmr_tmr_cfg_regs.sv
src/hmr_tmr_ctrl.sv
src/hmr_tmr_mismatch_cnt.sv
src/hmr_tmr_unit.sv
tests/tb_clk_gen.sv
tests/tb_hmr_tmr_checker.sv
tests/tb_hmr_tmr_unit.sv

/* run_sim.sh */
#!/bin/sh
# Build the TMR control unit testbench with Verilator and run it

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -j 0 \
  --top-module tb_hmr_tmr_unit -f src.f --Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "TESTBENCH PASSED" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1
